// File: include/vseq_defines.svh
////////////////////////////////////////////////////////////
// Vector sequencer sizing
// Instruction ID count, register file size and unit queue depths
////////////////////////////////////////////////////////////

`ifndef VSEQ_DEFINES_SVH
`define VSEQ_DEFINES_SVH

// Instruction IDs that can be in flight at the same time
`define VSEQ_NR_VINSN 4

// Architectural vector registers
`define VSEQ_NR_VREGS 32

// Instruction queue depth of each functional unit
`define VSEQ_ALU_DEPTH 2
`define VSEQ_MUL_DEPTH 2
`define VSEQ_LD_DEPTH 1
`define VSEQ_ST_DEPTH 1

// Occupancy counter width, large enough to hold the deepest queue
`define VSEQ_CNT_W 2

// Width of a scalar operand or a scalar result
`define VSEQ_XLEN 32

`endif

// File: logic/vseq_pkg.sv
////////////////////////////////////////////////////////////
// Vector sequencer package
// Shared types, opcode and unit encodings, opcode decoding
////////////////////////////////////////////////////////////

`include "vseq_defines.svh"

package vseq_pkg;

  // Real functional units, UNIT_NONE is not counted
  localparam int unsigned NR_UNITS = 4;

  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;
  typedef logic [`VSEQ_CNT_W-1:0] cnt_t;

  // The real units come first, so their encoding indexes per-unit arrays
  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_NONE
  } vseq_unit_e;

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VMUL,
    VMACC,
    VLE,
    VSE,
    VMVXS
  } vseq_op_e;

  typedef enum logic {
    IDLE,
    WAIT
  } seq_state_e;

  // Unit that executes an opcode
  // The scalar move has no queue of its own and maps to UNIT_NONE
  function automatic vseq_unit_e vseq_op_unit(vseq_op_e op);
    vseq_unit_e unit;
    case (op)
      VADD, VSUB, VAND: unit = UNIT_ALU;
      VMUL, VMACC:      unit = UNIT_MUL;
      VLE:              unit = UNIT_LOAD;
      VSE:              unit = UNIT_STORE;
      default:          unit = UNIT_NONE;
    endcase
    return unit;
  endfunction

endpackage

// File: logic/vseq_id_tracker.sv
////////////////////////////////////////////////////////////
// Instruction ID tracker
// Running-ID vector, lowest free ID and idle flag
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "vseq_defines.svh"

module vseq_id_tracker (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    alloc_i,
  input  logic [vseq_pkg::NR_UNITS-1:0]           unit_done_i,
  input  vseq_pkg::vid_t [vseq_pkg::NR_UNITS-1:0] unit_done_id_i,
  output vseq_pkg::vid_t                          free_id_o,
  output logic                                    full_o,
  output logic [`VSEQ_NR_VINSN-1:0]               running_o,
  output logic                                    idle_o
);

  import vseq_pkg::*;

  // A set bit marks an ID that was issued and has not completed yet
  logic [`VSEQ_NR_VINSN-1:0] running_d, running_q;
  logic [`VSEQ_NR_VINSN-1:0] done_mask;

  // Every unit can retire one ID per cycle, gather them into one mask
  always_comb begin
    done_mask = '0;
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      if (unit_done_i[u]) begin
        done_mask[unit_done_id_i[u]] = 1'b1;
      end
    end
  end

  // Priority scan from the top down, so the lowest clear bit wins
  // The scan looks at the registered vector only, which keeps ready free of done paths
  always_comb begin
    free_id_o = '0;
    full_o    = 1'b1;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        free_id_o = vid_t'(i);
        full_o    = 1'b0;
      end
    end
  end

  // Retire first, then allocate, the allocated ID is never one being retired
  always_comb begin
    running_d = running_q & ~done_mask;
    if (alloc_i) begin
      running_d[free_id_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  assign running_o = running_q;
  assign idle_o    = ~|running_q;

endmodule

// File: logic/vseq_hazard_check.sv
////////////////////////////////////////////////////////////
// Register hazard check
// Tracks the writers of every vector register and builds the
// dependency vector of the incoming instruction (RAW and WAW)
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "vseq_defines.svh"

module vseq_hazard_check (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      record_i,
  input  vseq_pkg::vid_t            new_id_i,
  input  vseq_pkg::vreg_t           vs1_i,
  input  vseq_pkg::vreg_t           vs2_i,
  input  vseq_pkg::vreg_t           vd_i,
  input  logic                      use_vs1_i,
  input  logic                      use_vs2_i,
  input  logic                      use_vd_i,
  input  logic [`VSEQ_NR_VINSN-1:0] running_i,
  output logic [`VSEQ_NR_VINSN-1:0] deps_o
);

  //////////////////////////////////////////////////////////
  // Writer list
  //////////////////////////////////////////////////////////

  // Row r holds one bit per ID, set while that ID writes register r
  logic [`VSEQ_NR_VREGS-1:0][`VSEQ_NR_VINSN-1:0] write_list_d, write_list_q;

  // Writers of each source, with finished instructions masked off
  logic [`VSEQ_NR_VINSN-1:0] live_vs1;
  logic [`VSEQ_NR_VINSN-1:0] live_vs2;
  logic [`VSEQ_NR_VINSN-1:0] live_vd;

  assign live_vs1 = write_list_q[vs1_i] & running_i;
  assign live_vs2 = write_list_q[vs2_i] & running_i;
  assign live_vd  = write_list_q[vd_i] & running_i;

  // A read of vs1 or vs2 gives RAW, a match on vd gives WAW
  // The same bit covers both, the units only need to know whom to wait for
  assign deps_o = ({`VSEQ_NR_VINSN{use_vs1_i}} & live_vs1) |
                  ({`VSEQ_NR_VINSN{use_vs2_i}} & live_vs2) |
                  ({`VSEQ_NR_VINSN{use_vd_i}} & live_vd);

  //////////////////////////////////////////////////////////
  // List update
  //////////////////////////////////////////////////////////

  // Stale writers are dropped every cycle before the new one is marked
  // A reused ID therefore never inherits the registers of its previous owner
  always_comb begin
    for (int unsigned r = 0; r < `VSEQ_NR_VREGS; r++) begin
      write_list_d[r] = write_list_q[r] & running_i;
    end
    // Older writers of vd stay listed, so later readers wait for all of them
    if (record_i && use_vd_i) begin
      write_list_d[vd_i][new_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_list_q <= '0;
    end else begin
      write_list_q <= write_list_d;
    end
  end

endmodule

// File: logic/vseq_unit_credits.sv
////////////////////////////////////////////////////////////
// Unit queue credits
// One occupancy counter per functional unit and its ready flag
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "vseq_defines.svh"

module vseq_unit_credits (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          accept_i,
  input  vseq_pkg::vseq_unit_e          accept_unit_i,
  input  logic [vseq_pkg::NR_UNITS-1:0] unit_done_i,
  output logic [vseq_pkg::NR_UNITS-1:0] unit_ready_o
);

  import vseq_pkg::*;

  // Queue depth of each unit, in the order of the unit encoding
  localparam int unsigned UNIT_DEPTH [NR_UNITS] = '{
    `VSEQ_ALU_DEPTH,
    `VSEQ_MUL_DEPTH,
    `VSEQ_LD_DEPTH,
    `VSEQ_ST_DEPTH
  };

  cnt_t [NR_UNITS-1:0] cnt_q;

  for (genvar u = 0; u < NR_UNITS; u++) begin : gen_unit_cnt
    logic cnt_up;
    logic cnt_down;

    // An accepted instruction takes a slot, a done pulse gives it back
    assign cnt_up   = accept_i && (accept_unit_i == vseq_unit_e'(u));
    assign cnt_down = unit_done_i[u];

    // Up and down in the same cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else begin
        case ({cnt_up, cnt_down})
          2'b10:   cnt_q[u] <= cnt_q[u] + cnt_t'(1);
          2'b01:   cnt_q[u] <= cnt_q[u] - cnt_t'(1);
          default: cnt_q[u] <= cnt_q[u];
        endcase
      end
    end

    // Room is left while the count is below the depth
    assign unit_ready_o[u] = cnt_q[u] < cnt_t'(UNIT_DEPTH[u]);
  end

endmodule

// File: logic/vseq_issue_ctrl.sv
////////////////////////////////////////////////////////////
// Issue control
// IDLE/WAIT FSM, request acceptance, issue register and
// forwarding of the scalar move result
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "vseq_defines.svh"

module vseq_issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  input  vseq_pkg::vseq_op_e            req_op_i,
  input  vseq_pkg::vreg_t               req_vs1_i,
  input  vseq_pkg::vreg_t               req_vs2_i,
  input  vseq_pkg::vreg_t               req_vd_i,
  input  logic                          req_use_vs1_i,
  input  logic                          req_use_vs2_i,
  input  logic                          req_use_vd_i,
  input  logic [`VSEQ_XLEN-1:0]         req_scalar_i,
  output logic                          req_ready_o,
  input  vseq_pkg::vid_t                free_id_i,
  input  logic                          full_i,
  input  logic [vseq_pkg::NR_UNITS-1:0] unit_ready_i,
  input  logic [`VSEQ_NR_VINSN-1:0]     deps_i,
  input  logic                          scalar_resp_valid_i,
  input  logic [`VSEQ_XLEN-1:0]         scalar_resp_i,
  output logic                          accept_o,
  output vseq_pkg::vseq_unit_e          accept_unit_o,
  output logic                          pe_valid_o,
  output vseq_pkg::vseq_op_e            pe_op_o,
  output vseq_pkg::vseq_unit_e          pe_unit_o,
  output vseq_pkg::vid_t                pe_id_o,
  output vseq_pkg::vreg_t               pe_vs1_o,
  output vseq_pkg::vreg_t               pe_vs2_o,
  output vseq_pkg::vreg_t               pe_vd_o,
  output logic [`VSEQ_XLEN-1:0]         pe_scalar_o,
  output logic [`VSEQ_NR_VINSN-1:0]     pe_deps_o,
  output logic                          resp_valid_o,
  output logic [`VSEQ_XLEN-1:0]         resp_data_o
);

  import vseq_pkg::*;

  seq_state_e state_d, state_q;
  vseq_unit_e req_unit;
  logic       unit_ok;
  logic       req_fire;

  assign req_unit = vseq_op_unit(req_op_i);

  // Only a real unit can be out of queue slots
  always_comb begin
    unit_ok = 1'b1;
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      if (req_unit == vseq_unit_e'(u)) begin
        unit_ok = unit_ready_i[u];
      end
    end
  end

  // Ready depends on registered state only, never on req_valid_i
  assign req_ready_o = (state_q == IDLE) && !full_i && unit_ok;
  assign req_fire    = req_valid_i && req_ready_o;

  // A scalar move is issued but holds neither an ID nor a queue slot,
  // since no unit ever reports it done
  assign accept_o      = req_fire && (req_unit != UNIT_NONE);
  assign accept_unit_o = req_unit;

  //////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    resp_valid_o = 1'b0;
    resp_data_o  = '0;
    case (state_q)
      IDLE: begin
        // The dispatcher waits for the scalar result of a move
        if (req_fire && (req_unit == UNIT_NONE)) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        // Result goes straight through in the cycle it shows up
        if (scalar_resp_valid_i) begin
          resp_valid_o = 1'b1;
          resp_data_o  = scalar_resp_i;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      pe_valid_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Units always take the issue, so this is a single-cycle pulse
      pe_valid_o <= req_fire;
    end
  end

  // Issue payload, only meaningful while pe_valid_o is high
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      pe_op_o     <= req_op_i;
      pe_unit_o   <= req_unit;
      pe_id_o     <= free_id_i;
      pe_vs1_o    <= req_vs1_i;
      pe_vs2_o    <= req_vs2_i;
      pe_vd_o     <= req_vd_i;
      pe_scalar_o <= req_scalar_i;
      pe_deps_o   <= deps_i;
    end
  end

endmodule

// File: logic/vseq_top.sv
////////////////////////////////////////////////////////////
// Vector instruction sequencer
// Accepts decoded instructions, assigns IDs, resolves register
// dependencies and unit queue room, issues to the units
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "vseq_defines.svh"

module vseq_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Dispatcher request
  input  logic                                    req_valid_i,
  input  vseq_pkg::vseq_op_e                      req_op_i,
  input  vseq_pkg::vreg_t                         req_vs1_i,
  input  vseq_pkg::vreg_t                         req_vs2_i,
  input  vseq_pkg::vreg_t                         req_vd_i,
  input  logic                                    req_use_vs1_i,
  input  logic                                    req_use_vs2_i,
  input  logic                                    req_use_vd_i,
  input  logic [`VSEQ_XLEN-1:0]                   req_scalar_i,
  output logic                                    req_ready_o,
  // Issue to the units
  output logic                                    pe_valid_o,
  output vseq_pkg::vseq_op_e                      pe_op_o,
  output vseq_pkg::vseq_unit_e                    pe_unit_o,
  output vseq_pkg::vid_t                          pe_id_o,
  output vseq_pkg::vreg_t                         pe_vs1_o,
  output vseq_pkg::vreg_t                         pe_vs2_o,
  output vseq_pkg::vreg_t                         pe_vd_o,
  output logic [`VSEQ_XLEN-1:0]                   pe_scalar_o,
  output logic [`VSEQ_NR_VINSN-1:0]               pe_deps_o,
  // Completions from the units
  input  logic [vseq_pkg::NR_UNITS-1:0]           unit_done_i,
  input  vseq_pkg::vid_t [vseq_pkg::NR_UNITS-1:0] unit_done_id_i,
  // Scalar move result and status
  input  logic                                    scalar_resp_valid_i,
  input  logic [`VSEQ_XLEN-1:0]                   scalar_resp_i,
  output logic                                    resp_valid_o,
  output logic [`VSEQ_XLEN-1:0]                   resp_data_o,
  output logic                                    idle_o
);

  import vseq_pkg::*;

  vid_t                      free_id;
  logic                      id_full;
  logic [`VSEQ_NR_VINSN-1:0] running;
  logic [`VSEQ_NR_VINSN-1:0] deps;
  logic [NR_UNITS-1:0]       unit_ready;
  logic                      accept;
  vseq_unit_e                accept_unit;

  vseq_id_tracker i_id_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .alloc_i        (accept),
    .unit_done_i    (unit_done_i),
    .unit_done_id_i (unit_done_id_i),
    .free_id_o      (free_id),
    .full_o         (id_full),
    .running_o      (running),
    .idle_o         (idle_o)
  );

  // The request fields feed the hazard check directly, deps is ready before acceptance
  vseq_hazard_check i_hazard_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .record_i  (accept),
    .new_id_i  (free_id),
    .vs1_i     (req_vs1_i),
    .vs2_i     (req_vs2_i),
    .vd_i      (req_vd_i),
    .use_vs1_i (req_use_vs1_i),
    .use_vs2_i (req_use_vs2_i),
    .use_vd_i  (req_use_vd_i),
    .running_i (running),
    .deps_o    (deps)
  );

  vseq_unit_credits i_unit_credits (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .accept_unit_i (accept_unit),
    .unit_done_i   (unit_done_i),
    .unit_ready_o  (unit_ready)
  );

  vseq_issue_ctrl i_issue_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_valid_i         (req_valid_i),
    .req_op_i            (req_op_i),
    .req_vs1_i           (req_vs1_i),
    .req_vs2_i           (req_vs2_i),
    .req_vd_i            (req_vd_i),
    .req_use_vs1_i       (req_use_vs1_i),
    .req_use_vs2_i       (req_use_vs2_i),
    .req_use_vd_i        (req_use_vd_i),
    .req_scalar_i        (req_scalar_i),
    .req_ready_o         (req_ready_o),
    .free_id_i           (free_id),
    .full_i              (id_full),
    .unit_ready_i        (unit_ready),
    .deps_i              (deps),
    .scalar_resp_valid_i (scalar_resp_valid_i),
    .scalar_resp_i       (scalar_resp_i),
    .accept_o            (accept),
    .accept_unit_o       (accept_unit),
    .pe_valid_o          (pe_valid_o),
    .pe_op_o             (pe_op_o),
    .pe_unit_o           (pe_unit_o),
    .pe_id_o             (pe_id_o),
    .pe_vs1_o            (pe_vs1_o),
    .pe_vs2_o            (pe_vs2_o),
    .pe_vd_o             (pe_vd_o),
    .pe_scalar_o         (pe_scalar_o),
    .pe_deps_o           (pe_deps_o),
    .resp_valid_o        (resp_valid_o),
    .resp_data_o         (resp_data_o)
  );

endmodule

// File: verification/vseq_tb.sv
////////////////////////////////////////////////////////////
// Vector sequencer testbench
// Applies a table of dispatcher requests, models the units'
// completions and checks issue, dependencies, stalls and
// the scalar move response
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "vseq_defines.svh"

module vseq_tb;

  import vseq_pkg::*;

  localparam int NR_ROWS         = 11;
  localparam int WATCHDOG_CYCLES = NR_ROWS * 60;
  // Cycles a blocked request is held before the unit model frees a slot
  localparam int STALL_CYCLES    = 2;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_valid_i;
  vseq_op_e                      req_op_i;
  vreg_t                         req_vs1_i;
  vreg_t                         req_vs2_i;
  vreg_t                         req_vd_i;
  logic                          req_use_vs1_i;
  logic                          req_use_vs2_i;
  logic                          req_use_vd_i;
  logic [`VSEQ_XLEN-1:0]         req_scalar_i;
  logic                          req_ready_o;
  logic                          pe_valid_o;
  vseq_op_e                      pe_op_o;
  vseq_unit_e                    pe_unit_o;
  vid_t                          pe_id_o;
  vreg_t                         pe_vs1_o;
  vreg_t                         pe_vs2_o;
  vreg_t                         pe_vd_o;
  logic [`VSEQ_XLEN-1:0]         pe_scalar_o;
  logic [`VSEQ_NR_VINSN-1:0]     pe_deps_o;
  logic [NR_UNITS-1:0]           unit_done_i;
  vid_t [NR_UNITS-1:0]           unit_done_id_i;
  logic                          scalar_resp_valid_i;
  logic [`VSEQ_XLEN-1:0]         scalar_resp_i;
  logic                          resp_valid_o;
  logic [`VSEQ_XLEN-1:0]         resp_data_o;
  logic                          idle_o;

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  vseq_op_e                  tab_op        [NR_ROWS];
  vreg_t                     tab_vs1       [NR_ROWS];
  vreg_t                     tab_vs2       [NR_ROWS];
  vreg_t                     tab_vd        [NR_ROWS];
  // Use flags ordered as {vs1, vs2, vd}
  logic [2:0]                tab_use       [NR_ROWS];
  logic [`VSEQ_XLEN-1:0]     tab_scalar    [NR_ROWS];
  // Completions released before the request is presented
  vseq_unit_e                tab_pre_unit  [NR_ROWS];
  int                        tab_pre_n     [NR_ROWS];
  // Completions released while the request is held off, a stall is expected first
  vseq_unit_e                tab_post_unit [NR_ROWS];
  int                        tab_post_n    [NR_ROWS];
  vseq_unit_e                tab_unit      [NR_ROWS];
  vid_t                      tab_id        [NR_ROWS];
  logic [`VSEQ_NR_VINSN-1:0] tab_deps      [NR_ROWS];

  // IDs issued to each unit and not yet completed, oldest first
  vid_t alu_q[$];
  vid_t mul_q[$];
  vid_t ld_q[$];
  vid_t st_q[$];

  int value_errs;
  int other_errs;

  vseq_top i_vseq_top (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_valid_i         (req_valid_i),
    .req_op_i            (req_op_i),
    .req_vs1_i           (req_vs1_i),
    .req_vs2_i           (req_vs2_i),
    .req_vd_i            (req_vd_i),
    .req_use_vs1_i       (req_use_vs1_i),
    .req_use_vs2_i       (req_use_vs2_i),
    .req_use_vd_i        (req_use_vd_i),
    .req_scalar_i        (req_scalar_i),
    .req_ready_o         (req_ready_o),
    .pe_valid_o          (pe_valid_o),
    .pe_op_o             (pe_op_o),
    .pe_unit_o           (pe_unit_o),
    .pe_id_o             (pe_id_o),
    .pe_vs1_o            (pe_vs1_o),
    .pe_vs2_o            (pe_vs2_o),
    .pe_vd_o             (pe_vd_o),
    .pe_scalar_o         (pe_scalar_o),
    .pe_deps_o           (pe_deps_o),
    .unit_done_i         (unit_done_i),
    .unit_done_id_i      (unit_done_id_i),
    .scalar_resp_valid_i (scalar_resp_valid_i),
    .scalar_resp_i       (scalar_resp_i),
    .resp_valid_o        (resp_valid_o),
    .resp_data_o         (resp_data_o),
    .idle_o              (idle_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic void add_row(input int i, input vseq_op_e op, input int vs1,
                                  input int vs2, input int vd, input logic [2:0] use_f,
                                  input logic [31:0] scalar, input vseq_unit_e pre_u,
                                  input int pre_n, input vseq_unit_e post_u, input int post_n,
                                  input vseq_unit_e unit, input int id, input logic [3:0] deps);
    tab_op[i]        = op;
    tab_vs1[i]       = vreg_t'(vs1);
    tab_vs2[i]       = vreg_t'(vs2);
    tab_vd[i]        = vreg_t'(vd);
    tab_use[i]       = use_f;
    tab_scalar[i]    = scalar;
    tab_pre_unit[i]  = pre_u;
    tab_pre_n[i]     = pre_n;
    tab_post_unit[i] = post_u;
    tab_post_n[i]    = post_n;
    tab_unit[i]      = unit;
    tab_id[i]        = vid_t'(id);
    tab_deps[i]      = deps;
  endfunction

  // Rows 0 to 3 fill every ID, row 4 waits on a full ID set and reuses ID 0,
  // row 5 waits on a full ALU queue, row 7 is the scalar move
  function automatic void load_table();
    add_row(0,  VMUL,  2,  3,  1,  3'b111, 32'h0, UNIT_NONE,  0, UNIT_NONE, 0, UNIT_MUL,   0, 4'b0000);
    add_row(1,  VADD,  1,  4,  5,  3'b111, 32'h0, UNIT_NONE,  0, UNIT_NONE, 0, UNIT_ALU,   1, 4'b0001);
    add_row(2,  VLE,   0,  0,  6,  3'b001, 32'h0, UNIT_NONE,  0, UNIT_NONE, 0, UNIT_LOAD,  2, 4'b0000);
    add_row(3,  VSE,   0,  7,  0,  3'b010, 32'h0, UNIT_NONE,  0, UNIT_NONE, 0, UNIT_STORE, 3, 4'b0000);
    add_row(4,  VSUB,  8,  9,  5,  3'b111, 32'h0, UNIT_NONE,  0, UNIT_MUL,  1, UNIT_ALU,   0, 4'b0010);
    add_row(5,  VADD,  1,  6,  10, 3'b111, 32'h0, UNIT_LOAD,  1, UNIT_ALU,  1, UNIT_ALU,   1, 4'b0000);
    add_row(6,  VMACC, 10, 5,  11, 3'b111, 32'h0, UNIT_NONE,  0, UNIT_NONE, 0, UNIT_MUL,   2, 4'b0011);
    add_row(7,  VMVXS, 0,  11, 0,  3'b010, 32'h5a3c96e1, UNIT_STORE, 1, UNIT_NONE, 0,
            UNIT_NONE, 3, 4'b0100);
    add_row(8,  VAND,  11, 12, 11, 3'b111, 32'h0, UNIT_ALU,   1, UNIT_NONE, 0, UNIT_ALU,   0, 4'b0100);
    add_row(9,  VLE,   0,  0,  5,  3'b001, 32'h0, UNIT_NONE,  0, UNIT_NONE, 0, UNIT_LOAD,  3, 4'b0000);
    add_row(10, VSE,   0,  5,  0,  3'b010, 32'h0, UNIT_MUL,   1, UNIT_NONE, 0, UNIT_STORE, 2, 4'b1000);
  endfunction

  function automatic void fail_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
    value_errs++;
    $display("Fail %s at %0t ns: got 0x%h, expected 0x%h", name, $time, got, exp);
  endfunction

  ////////////////////////////////////////////////////////////
  // Unit completion model
  ////////////////////////////////////////////////////////////

  function automatic void push_id(input vseq_unit_e unit, input vid_t id);
    case (unit)
      UNIT_ALU:   alu_q.push_back(id);
      UNIT_MUL:   mul_q.push_back(id);
      UNIT_LOAD:  ld_q.push_back(id);
      UNIT_STORE: st_q.push_back(id);
      default:    ;
    endcase
  endfunction

  function automatic int queue_size(input vseq_unit_e unit);
    int n;
    case (unit)
      UNIT_ALU:   n = alu_q.size();
      UNIT_MUL:   n = mul_q.size();
      UNIT_LOAD:  n = ld_q.size();
      UNIT_STORE: n = st_q.size();
      default:    n = 0;
    endcase
    return n;
  endfunction

  function automatic vid_t pop_id(input vseq_unit_e unit);
    vid_t id;
    id = '0;
    case (unit)
      UNIT_ALU:   id = alu_q.pop_front();
      UNIT_MUL:   id = mul_q.pop_front();
      UNIT_LOAD:  id = ld_q.pop_front();
      UNIT_STORE: id = st_q.pop_front();
      default:    id = '0;
    endcase
    return id;
  endfunction

  // One done pulse per cycle, oldest ID of the unit first
  // Called and returns 2 ns after a rising edge
  task automatic release_done(input vseq_unit_e unit, input int count);
    vid_t id;
    for (int n = 0; n < count; n++) begin
      if (queue_size(unit) == 0) begin
        other_errs++;
        $display("Unit %0d has no issued instruction left to complete", int'(unit));
      end else begin
        id                          = pop_id(unit);
        unit_done_id_i[int'(unit)] = id;
        unit_done_i[int'(unit)]    = 1'b1;
        @(posedge clk_i);
        #2;
        unit_done_i = '0;
      end
    end
  endtask

  // Entered at the falling edge of the issue cycle, the FSM sits in WAIT
  task automatic scalar_move(input int i);
    int wait_n;
    wait_n = 1 + ($urandom % 3);
    repeat (wait_n) begin
      @(posedge clk_i);
      #2;
      @(negedge clk_i);
      if (req_ready_o !== 1'b0) fail_value("req_ready_o", req_ready_o, 1'b0);
      if (resp_valid_o !== 1'b0) fail_value("resp_valid_o", resp_valid_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
    scalar_resp_valid_i = 1'b1;
    scalar_resp_i       = tab_scalar[i];
    @(negedge clk_i);
    if (resp_valid_o !== 1'b1) fail_value("resp_valid_o", resp_valid_o, 1'b1);
    if (resp_data_o !== tab_scalar[i]) fail_value("resp_data_o", resp_data_o, tab_scalar[i]);
    if (req_ready_o !== 1'b0) fail_value("req_ready_o", req_ready_o, 1'b0);
    @(posedge clk_i);
    #2;
    scalar_resp_valid_i = 1'b0;
    scalar_resp_i       = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Row sequencing
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int i);
    int gap;
    bit accepted;
    gap = $urandom % 3;
    repeat (gap) begin
      @(posedge clk_i);
      #2;
    end
    release_done(tab_pre_unit[i], tab_pre_n[i]);
    req_valid_i   = 1'b1;
    req_op_i      = tab_op[i];
    req_vs1_i     = tab_vs1[i];
    req_vs2_i     = tab_vs2[i];
    req_vd_i      = tab_vd[i];
    req_use_vs1_i = tab_use[i][2];
    req_use_vs2_i = tab_use[i][1];
    req_use_vd_i  = tab_use[i][0];
    req_scalar_i  = tab_scalar[i];
    // Held off by a full queue or no free ID until the model completes something
    if (tab_post_n[i] > 0) begin
      repeat (STALL_CYCLES) begin
        @(negedge clk_i);
        if (req_ready_o !== 1'b0) fail_value("req_ready_o", req_ready_o, 1'b0);
        @(posedge clk_i);
        #2;
      end
      release_done(tab_post_unit[i], tab_post_n[i]);
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      if (pe_valid_o !== 1'b0) fail_value("pe_valid_o", pe_valid_o, 1'b0);
      accepted = req_ready_o;
      @(posedge clk_i);
      #2;
    end
    req_valid_i = 1'b0;
    // The issue pulse belongs to the cycle right after acceptance
    @(negedge clk_i);
    if (pe_valid_o !== 1'b1) fail_value("pe_valid_o", pe_valid_o, 1'b1);
    if (pe_op_o !== tab_op[i]) fail_value("pe_op_o", pe_op_o, tab_op[i]);
    if (pe_unit_o !== tab_unit[i]) fail_value("pe_unit_o", pe_unit_o, tab_unit[i]);
    if (pe_id_o !== tab_id[i]) fail_value("pe_id_o", pe_id_o, tab_id[i]);
    if (pe_deps_o !== tab_deps[i]) fail_value("pe_deps_o", pe_deps_o, tab_deps[i]);
    if (pe_vs1_o !== tab_vs1[i]) fail_value("pe_vs1_o", pe_vs1_o, tab_vs1[i]);
    if (pe_vs2_o !== tab_vs2[i]) fail_value("pe_vs2_o", pe_vs2_o, tab_vs2[i]);
    if (pe_vd_o !== tab_vd[i]) fail_value("pe_vd_o", pe_vd_o, tab_vd[i]);
    if (pe_scalar_o !== tab_scalar[i]) fail_value("pe_scalar_o", pe_scalar_o, tab_scalar[i]);
    if (tab_unit[i] == UNIT_NONE) begin
      if (req_ready_o !== 1'b0) fail_value("req_ready_o", req_ready_o, 1'b0);
      scalar_move(i);
    end else begin
      if (idle_o !== 1'b0) fail_value("idle_o", idle_o, 1'b0);
      push_id(tab_unit[i], tab_id[i]);
      @(posedge clk_i);
      #2;
    end
  endtask

  initial begin
    void'($urandom(32'h2431966d));
    value_errs          = 0;
    other_errs          = 0;
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    req_valid_i         = 1'b0;
    req_op_i            = VADD;
    req_vs1_i           = '0;
    req_vs2_i           = '0;
    req_vd_i            = '0;
    req_use_vs1_i       = 1'b0;
    req_use_vs2_i       = 1'b0;
    req_use_vd_i        = 1'b0;
    req_scalar_i        = '0;
    unit_done_i         = '0;
    unit_done_id_i      = '0;
    scalar_resp_valid_i = 1'b0;
    scalar_resp_i       = '0;
    load_table();
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (idle_o !== 1'b1) fail_value("idle_o", idle_o, 1'b1);
    if (req_ready_o !== 1'b1) fail_value("req_ready_o", req_ready_o, 1'b1);
    if (pe_valid_o !== 1'b0) fail_value("pe_valid_o", pe_valid_o, 1'b0);
    if (resp_valid_o !== 1'b0) fail_value("resp_valid_o", resp_valid_o, 1'b0);
    @(posedge clk_i);
    #2;
    for (int i = 0; i < NR_ROWS; i++) begin
      run_row(i);
    end
    // Complete everything still in flight, the sequencer must go idle
    release_done(UNIT_ALU, alu_q.size());
    release_done(UNIT_MUL, mul_q.size());
    release_done(UNIT_LOAD, ld_q.size());
    release_done(UNIT_STORE, st_q.size());
    @(negedge clk_i);
    if (idle_o !== 1'b1) fail_value("idle_o", idle_o, 1'b1);
    if (req_ready_o !== 1'b1) fail_value("req_ready_o", req_ready_o, 1'b1);
    $display("Run complete: %0d value errors, %0d other errors", value_errs, other_errs);
    if ((value_errs + other_errs) == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
logic/vseq_pkg.sv
logic/vseq_id_tracker.sv
logic/vseq_hazard_check.sv
logic/vseq_unit_credits.sv
logic/vseq_issue_ctrl.sv
logic/vseq_top.sv
verification/vseq_tb.sv

// File: Bender.yml
package:
  name: vseq

export_include_dirs:
  - include

sources:
  - logic/vseq_pkg.sv
  - logic/vseq_id_tracker.sv
  - logic/vseq_hazard_check.sv
  - logic/vseq_unit_credits.sv
  - logic/vseq_issue_ctrl.sv
  - logic/vseq_top.sv
  - target: test
    files:
      - verification/vseq_tb.sv
